// File: all.f
source/crc_pkg.sv
source/csr_registers.sv
source/core_assignment_table.sv
source/comparison_window.sv
source/fingerprint_comparator.sv
source/crc_comparator_top.sv
bench/crc_comparator_tb.sv

// File: bench/crc_comparator_tb.sv
`timescale 1ns/1ps

module crc_comparator_tb;

	localparam int clk_period = 100;
	localparam int cycles_per_line = 40;
	localparam int bus_limit = 10;
	localparam int irq_limit = 12;

	logic clk;
	logic reset;
	logic [crc_pkg::csr_addr_width-1:0] csr_address;
	logic csr_read;
	logic csr_write;
	logic [crc_pkg::data_width-1:0] csr_writedata;
	logic [crc_pkg::data_width-1:0] csr_readdata;
	logic csr_waitrequest;
	logic fprint_write;
	logic [crc_pkg::key_width-1:0] fprint_physical_core;
	logic [crc_pkg::data_width-1:0] fprint_data;
	logic irq;

	// one entry per vector line
	logic [7:0] ops [$];
	logic [31:0] arg_a [$];
	logic [31:0] arg_b [$];
	logic vectors_loaded;
	int errors;
	int checks;

	crc_comparator_top dut_i (
		.clk(clk), .reset(reset),
		.csr_address(csr_address), .csr_read(csr_read), .csr_write(csr_write),
		.csr_writedata(csr_writedata), .csr_readdata(csr_readdata),
		.csr_waitrequest(csr_waitrequest),
		.fprint_write(fprint_write), .fprint_physical_core(fprint_physical_core),
		.fprint_data(fprint_data), .irq(irq)
	);

	always #(clk_period / 2) clk = ~clk;

	// cycles from the sampling edge to waitrequest low
	function automatic int write_latency(input logic [7:0] addr);
		if (addr == crc_pkg::exception_offset)
			return 2;
		if (addr == crc_pkg::maxcount_offset || addr == crc_pkg::cat_offset ||
			addr[7:4] == crc_pkg::pointer_start_dir || addr[7:4] == crc_pkg::pointer_end_dir)
			return 3;
		return 1;
	endfunction

	task automatic load_vectors();
		int fd;
		int code;
		int c;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("bench/crc_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vector file bench/crc_vectors.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", op);
			if (code != 1)
				break;
			if (op == "#") begin
				do
					c = $fgetc(fd);
				while (c != "\n" && c != -1);
			end else if (op == "I") begin
				code = $fscanf(fd, "%h", a);
				ops.push_back(op);
				arg_a.push_back(a);
				arg_b.push_back(32'h0);
			end else if (op == "W" || op == "R" || op == "F") begin
				code = $fscanf(fd, "%h %h", a, b);
				ops.push_back(op);
				arg_a.push_back(a);
				arg_b.push_back(b);
			end else begin
				$display("unknown operation %c in the vector file", op);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	// held until waitrequest drops, cycles is -1 when it never does
	task automatic bus_access(input logic is_write, input logic [7:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output int cycles);
		@(posedge clk);
		#5;
		csr_address = addr;
		csr_writedata = data;
		csr_write = is_write;
		csr_read = !is_write;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (csr_waitrequest && cycles < bus_limit);
		rdata = csr_readdata;
		if (csr_waitrequest)
			cycles = -1;
		@(posedge clk);
		#5;
		csr_write = 1'b0;
		csr_read = 1'b0;
	endtask

	task automatic write_register(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		int cycles;
		bus_access(1'b1, addr, data, rdata, cycles);
		checks++;
		assert (cycles >= 0) else begin
			errors++;
			$display("write to address %h never completed", addr);
		end
		if (cycles >= 0)
			assert (cycles == write_latency(addr)) else begin
				errors++;
				$display("error at %0t: write to %h took %0d cycles, expected %0d",
					$time, addr, cycles, write_latency(addr));
			end
	endtask

	task automatic read_register(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] rdata;
		int cycles;
		bus_access(1'b0, addr, 32'h0, rdata, cycles);
		checks++;
		assert (cycles == 2) else begin
			errors++;
			$display("error at %0t: read of %h took %0d cycles, expected 2",
				$time, addr, cycles);
		end
		assert (rdata === expected) else begin
			errors++;
			$display("error at %0t: read of %h returned %h, expected %h",
				$time, addr, rdata, expected);
		end
	endtask

	task automatic send_fingerprint(input logic [3:0] core, input logic [31:0] data);
		@(posedge clk);
		#5;
		fprint_write = 1'b1;
		fprint_physical_core = core;
		fprint_data = data;
		@(posedge clk);
		#5;
		fprint_write = 1'b0;
	endtask

	task automatic check_irq(input logic level);
		int cycles;
		logic irq_seen;
		cycles = 0;
		irq_seen = 1'b0;
		if (level) begin
			while (irq !== 1'b1 && cycles < irq_limit) begin
				@(posedge clk);
				#1;
				cycles++;
			end
			irq_seen = (irq === 1'b1);
			// status ack follows irq, register FSM idle one cycle later
			if (irq_seen)
				repeat (2) @(posedge clk);
		end else begin
			// irq must stay low over the whole window
			repeat (irq_limit) begin
				@(posedge clk);
				#1;
				if (irq !== 1'b0)
					irq_seen = 1'b1;
			end
		end
		checks++;
		assert (irq_seen == level) else begin
			errors++;
			$display("error at %0t: irq expected %0b within %0d cycles",
				$time, level, irq_limit);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		csr_address = '0;
		csr_read = 1'b0;
		csr_write = 1'b0;
		csr_writedata = '0;
		fprint_write = 1'b0;
		fprint_physical_core = '0;
		fprint_data = '0;
		errors = 0;
		checks = 0;
		vectors_loaded = 1'b0;
		load_vectors();
		vectors_loaded = 1'b1;
		repeat (2) @(posedge clk);
		#5;
		reset = 1'b0;
		checks++;
		assert (irq === 1'b0 && csr_waitrequest === 1'b1) else begin
			errors++;
			$display("error at %0t: irq or waitrequest wrong after reset", $time);
		end
		for (int i = 0; i < ops.size(); i++) begin
			case (ops[i])
				"W": write_register(arg_a[i][7:0], arg_b[i]);
				"R": read_register(arg_a[i][7:0], arg_b[i]);
				"F": send_fingerprint(arg_a[i][3:0], arg_b[i]);
				default: check_irq(arg_a[i][0]);
			endcase
		end
		@(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		wait (vectors_loaded === 1'b1);
		#((ops.size() + 2) * cycles_per_line * clk_period);
		$display("watchdog expired, the vectors did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: bench/crc_vectors.txt
# W addr data | R addr expected | F core fingerprint | I irq
# all fields hex
R 00 00000000
R 01 00000000
R 02 ffffffff
I 0
# cores 0,1 run task 3, cores 2,3 task 5, cores 4,5 task 9
W 04 00030000
W 04 01030001
W 04 00050002
W 04 01050003
W 04 00090004
W 04 01090005
W 03 00000002
W 10 00000002
W 20 00000007
W 05 12345678
R 05 00000000
# two matching pairs reach maxcount
F 0 a5a5a5a5
F 1 a5a5a5a5
I 0
F 0 5a5a0001
F 1 5a5a0001
I 1
R 00 00000031
R 01 00000008
W 00 00000000
# mismatch on task 5
F 2 11112222
F 3 33334444
I 1
R 00 00000053
R 01 00000000
R 02 fffff7ff
W 00 00000000
# task 9 outside the window, cores 7 and 8 unmapped
F 4 deadbeef
F 5 feedface
F 7 01234567
F 8 76543210
I 0
# second report waits for the clear
F 0 00000001
F 1 00000002
I 1
R 00 00000033
F 2 aaaa0000
F 3 bbbb0000
R 00 00000033
R 02 ffffff7f
W 00 00000000
I 1
R 00 00000053
R 02 fffff7ff

// File: source/comparison_window.sv
`timescale 1ns/1ps

module comparison_window (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  maxcount_write,
	input  logic                                  pointer_start_write,
	input  logic                                  pointer_end_write,
	input  logic [crc_pkg::ram_addr_width-1:0]    data,
	output logic                                  maxcount_ack,
	output logic                                  pointer_ack,
	output logic [crc_pkg::ram_addr_width-1:0]    maxcount,
	output logic [crc_pkg::ram_addr_width-1:0]    window_start,
	output logic [crc_pkg::ram_addr_width-1:0]    window_end
);

	logic maxcount_en;
	logic pointer_en;

	assign maxcount_en = maxcount_write && !maxcount_ack;
	// start and end share one ack line
	assign pointer_en = (pointer_start_write || pointer_end_write) && !pointer_ack;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			maxcount <= 1;
			window_start <= '0;
			window_end <= '1;
			maxcount_ack <= 1'b0;
			pointer_ack <= 1'b0;
		end else begin
			maxcount_ack <= maxcount_en;
			pointer_ack <= pointer_en;
			if (maxcount_en)
				maxcount <= data;
			if (pointer_en && pointer_start_write)
				window_start <= data;
			if (pointer_en && pointer_end_write)
				window_end <= data;
		end
	end

endmodule

// File: source/core_assignment_table.sv
`timescale 1ns/1ps

module core_assignment_table (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cat_write,
	input  logic [1:0]                        cat_logical,
	input  logic [crc_pkg::key_width-1:0]     cat_task,
	input  logic [crc_pkg::key_width-1:0]     cat_physical,
	output logic                              cat_ack,
	input  logic [crc_pkg::key_width-1:0]     lookup_core,
	output logic                              lookup_valid,
	output logic [crc_pkg::key_width-1:0]     lookup_task,
	output logic [1:0]                        lookup_logical
);

	logic [crc_pkg::key_size-1:0] entry_valid;
	logic [crc_pkg::key_width-1:0] task_table [crc_pkg::key_size];
	logic [1:0] logical_table [crc_pkg::key_size];
	logic write_en;

	// strobe stays high until acked, so take it once
	assign write_en = cat_write && !cat_ack;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			entry_valid <= '0;
			cat_ack <= 1'b0;
		end else begin
			cat_ack <= write_en;
			if (write_en)
				entry_valid[cat_physical] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (write_en) begin
			task_table[cat_physical] <= cat_task;
			logical_table[cat_physical] <= cat_logical;
		end
	end

	assign lookup_valid = entry_valid[lookup_core];
	assign lookup_task = task_table[lookup_core];
	assign lookup_logical = logical_table[lookup_core];

	cat_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		cat_ack |=> !cat_ack);

endmodule

// File: source/crc_comparator_top.sv
`timescale 1ns/1ps

module crc_comparator_top (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic [crc_pkg::csr_addr_width-1:0]   csr_address,
	input  logic                                 csr_read,
	input  logic                                 csr_write,
	input  logic [crc_pkg::data_width-1:0]       csr_writedata,
	output logic [crc_pkg::data_width-1:0]       csr_readdata,
	output logic                                 csr_waitrequest,
	input  logic                                 fprint_write,
	input  logic [crc_pkg::key_width-1:0]        fprint_physical_core,
	input  logic [crc_pkg::data_width-1:0]       fprint_data,
	output logic                                 irq
);

	logic [crc_pkg::key_width-1:0] comparator_task_id;
	logic [1:0] comparator_logical_core_id;
	logic comparator_status_write;
	logic comparator_mismatch_detected;
	logic csr_status_ack;
	logic csr_cat_write;
	logic fprint_cat_ack;
	logic csr_maxcount_write;
	logic counter_maxcount_ack;
	logic csr_pointer_start_write;
	logic csr_pointer_end_write;
	logic comp_pointer_ack;
	logic [1:0] csr_logical_core_id;
	logic [crc_pkg::key_width-1:0] csr_task_id;
	logic [crc_pkg::key_width-1:0] csr_physical_core_id;
	logic [crc_pkg::ram_addr_width-1:0] csr_pointer_data;
	logic [crc_pkg::key_width-1:0] lookup_core;
	logic lookup_valid;
	logic [crc_pkg::key_width-1:0] lookup_task;
	logic [1:0] lookup_logical;
	logic [crc_pkg::ram_addr_width-1:0] maxcount;
	logic [crc_pkg::ram_addr_width-1:0] window_start;
	logic [crc_pkg::ram_addr_width-1:0] window_end;

	// maxcount and pointer data are the same write data bits
	csr_registers csr_i (
		.clk(clk), .reset(reset),
		.csr_address(csr_address), .csr_read(csr_read), .csr_write(csr_write),
		.csr_writedata(csr_writedata), .csr_readdata(csr_readdata),
		.csr_waitrequest(csr_waitrequest),
		.comparator_task_id(comparator_task_id),
		.comparator_logical_core_id(comparator_logical_core_id),
		.comparator_status_write(comparator_status_write),
		.comparator_mismatch_detected(comparator_mismatch_detected),
		.csr_status_ack(csr_status_ack), .irq(irq),
		.csr_cat_write(csr_cat_write), .fprint_cat_ack(fprint_cat_ack),
		.csr_maxcount_write(csr_maxcount_write), .counter_maxcount_ack(counter_maxcount_ack),
		.csr_pointer_start_write(csr_pointer_start_write),
		.csr_pointer_end_write(csr_pointer_end_write), .comp_pointer_ack(comp_pointer_ack),
		.csr_logical_core_id(csr_logical_core_id), .csr_task_id(csr_task_id),
		.csr_physical_core_id(csr_physical_core_id),
		.csr_maxcount_data(), .csr_pointer_data(csr_pointer_data)
	);

	core_assignment_table cat_i (
		.clk(clk), .reset(reset),
		.cat_write(csr_cat_write), .cat_logical(csr_logical_core_id),
		.cat_task(csr_task_id), .cat_physical(csr_physical_core_id),
		.cat_ack(fprint_cat_ack), .lookup_core(lookup_core),
		.lookup_valid(lookup_valid), .lookup_task(lookup_task),
		.lookup_logical(lookup_logical)
	);

	comparison_window window_i (
		.clk(clk), .reset(reset),
		.maxcount_write(csr_maxcount_write),
		.pointer_start_write(csr_pointer_start_write),
		.pointer_end_write(csr_pointer_end_write),
		.data(csr_pointer_data),
		.maxcount_ack(counter_maxcount_ack), .pointer_ack(comp_pointer_ack),
		.maxcount(maxcount), .window_start(window_start), .window_end(window_end)
	);

	fingerprint_comparator comparator_i (
		.clk(clk), .reset(reset),
		.fprint_write(fprint_write), .fprint_physical_core(fprint_physical_core),
		.fprint_data(fprint_data), .lookup_core(lookup_core),
		.lookup_valid(lookup_valid), .lookup_task(lookup_task),
		.lookup_logical(lookup_logical), .maxcount(maxcount),
		.window_start(window_start), .window_end(window_end),
		.status_ack(csr_status_ack), .status_write(comparator_status_write),
		.status_task(comparator_task_id), .status_logical(comparator_logical_core_id),
		.status_mismatch(comparator_mismatch_detected)
	);

endmodule

// File: source/crc_pkg.sv
package crc_pkg;

	// bus and table sizes
	localparam int csr_addr_width = 8;
	localparam int data_width = 32;
	localparam int key_width = 4;
	localparam int key_size = 16;
	localparam int ram_addr_width = 4;

	// register map
	localparam logic [csr_addr_width-1:0] exception_offset = 8'h00;
	localparam logic [csr_addr_width-1:0] success_offset = 8'h01;
	localparam logic [csr_addr_width-1:0] fail_offset = 8'h02;
	localparam logic [csr_addr_width-1:0] maxcount_offset = 8'h03;
	localparam logic [csr_addr_width-1:0] cat_offset = 8'h04;

	// address bits 7..4 select a window pointer write
	localparam int dir_lsb = 4;
	localparam int dir_width = 4;
	localparam logic [dir_width-1:0] pointer_start_dir = 4'd1;
	localparam logic [dir_width-1:0] pointer_end_dir = 4'd2;

	// exception register fields
	localparam int irq_bit = 0;
	localparam int ex_bit = 1;
	localparam int task_lsb = 4;

	// fail field value of a task with no failure
	localparam logic [1:0] fail_none = 2'd3;

	// core assignment fields in the write data
	localparam int cat_logical_lsb = 24;
	localparam int cat_task_lsb = 16;
	localparam int cat_physical_lsb = 0;

endpackage

// File: source/csr_registers.sv
`timescale 1ns/1ps

module csr_registers (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [crc_pkg::csr_addr_width-1:0]     csr_address,
	input  logic                                   csr_read,
	input  logic                                   csr_write,
	input  logic [crc_pkg::data_width-1:0]         csr_writedata,
	output logic [crc_pkg::data_width-1:0]         csr_readdata,
	output logic                                   csr_waitrequest,
	input  logic [crc_pkg::key_width-1:0]          comparator_task_id,
	input  logic [1:0]                             comparator_logical_core_id,
	input  logic                                   comparator_status_write,
	input  logic                                   comparator_mismatch_detected,
	output logic                                   csr_status_ack,
	output logic                                   irq,
	output logic                                   csr_cat_write,
	input  logic                                   fprint_cat_ack,
	output logic                                   csr_maxcount_write,
	input  logic                                   counter_maxcount_ack,
	output logic                                   csr_pointer_start_write,
	output logic                                   csr_pointer_end_write,
	input  logic                                   comp_pointer_ack,
	output logic [1:0]                             csr_logical_core_id,
	output logic [crc_pkg::key_width-1:0]          csr_task_id,
	output logic [crc_pkg::key_width-1:0]          csr_physical_core_id,
	output logic [crc_pkg::ram_addr_width-1:0]     csr_maxcount_data,
	output logic [crc_pkg::ram_addr_width-1:0]     csr_pointer_data
);

	typedef enum logic [3:0] {
		st_idle,
		st_regs_write,
		st_cat_write,
		st_maxcount_write,
		st_pointer_start_write,
		st_pointer_end_write,
		st_read,
		st_waitrequest,
		st_report,
		st_status_ack
	} state_t;

	state_t state;

	logic [crc_pkg::data_width-1:0] exception_reg;
	logic [crc_pkg::key_size-1:0] success_reg;
	logic [2*crc_pkg::key_size-1:0] fail_reg;

	logic exception_sel;
	logic success_sel;
	logic fail_sel;
	logic cat_sel;
	logic maxcount_sel;
	logic pointer_start_sel;
	logic pointer_end_sel;
	logic report_accept;

	assign exception_sel = (csr_address == crc_pkg::exception_offset);
	assign success_sel = (csr_address == crc_pkg::success_offset);
	assign fail_sel = (csr_address == crc_pkg::fail_offset);
	assign maxcount_sel = (csr_address == crc_pkg::maxcount_offset);
	assign cat_sel = (csr_address == crc_pkg::cat_offset);
	assign pointer_start_sel =
		(csr_address[crc_pkg::dir_lsb +: crc_pkg::dir_width] == crc_pkg::pointer_start_dir);
	assign pointer_end_sel =
		(csr_address[crc_pkg::dir_lsb +: crc_pkg::dir_width] == crc_pkg::pointer_end_dir);

	// forwarded fields straight from the held write data
	assign csr_logical_core_id = csr_writedata[crc_pkg::cat_logical_lsb +: 2];
	assign csr_task_id = csr_writedata[crc_pkg::cat_task_lsb +: crc_pkg::key_width];
	assign csr_physical_core_id = csr_writedata[crc_pkg::cat_physical_lsb +: crc_pkg::key_width];
	assign csr_maxcount_data = csr_writedata[crc_pkg::ram_addr_width-1:0];
	assign csr_pointer_data = csr_writedata[crc_pkg::ram_addr_width-1:0];

	// processor accesses win over a pending report
	assign report_accept = (state == st_idle) && !csr_write && !csr_read &&
		comparator_status_write && !irq;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (csr_write) begin
						if (exception_sel)
							state <= st_regs_write;
						else if (cat_sel)
							state <= st_cat_write;
						else if (maxcount_sel)
							state <= st_maxcount_write;
						else if (pointer_start_sel)
							state <= st_pointer_start_write;
						else if (pointer_end_sel)
							state <= st_pointer_end_write;
						else
							state <= st_waitrequest;
					end else if (csr_read) begin
						state <= st_read;
					end else if (report_accept) begin
						state <= st_report;
					end
				end
				st_regs_write: state <= st_waitrequest;
				st_cat_write: if (fprint_cat_ack) state <= st_waitrequest;
				st_maxcount_write: if (counter_maxcount_ack) state <= st_waitrequest;
				st_pointer_start_write: if (comp_pointer_ack) state <= st_waitrequest;
				st_pointer_end_write: if (comp_pointer_ack) state <= st_waitrequest;
				st_read: state <= st_waitrequest;
				st_report: state <= st_status_ack;
				default: state <= st_idle;
			endcase
		end
	end

	assign csr_cat_write = (state == st_cat_write);
	assign csr_maxcount_write = (state == st_maxcount_write);
	assign csr_pointer_start_write = (state == st_pointer_start_write);
	assign csr_pointer_end_write = (state == st_pointer_end_write);
	assign csr_waitrequest = (state != st_waitrequest);
	assign csr_status_ack = (state == st_status_ack);
	assign irq = exception_reg[crc_pkg::irq_bit];

	always_ff @(posedge clk) begin
		if (state == st_read) begin
			if (exception_sel)
				csr_readdata <= exception_reg;
			else if (success_sel)
				csr_readdata <= crc_pkg::data_width'(success_reg);
			else if (fail_sel)
				csr_readdata <= fail_reg;
			else
				csr_readdata <= '0;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exception_reg <= '0;
			success_reg <= '0;
			fail_reg <= {crc_pkg::key_size{crc_pkg::fail_none}};
		end else if (state == st_regs_write) begin
			exception_reg <= csr_writedata;
			success_reg <= '0;
			fail_reg <= {crc_pkg::key_size{crc_pkg::fail_none}};
		end else if (report_accept) begin
			exception_reg[crc_pkg::irq_bit] <= 1'b1;
			exception_reg[crc_pkg::ex_bit] <= comparator_mismatch_detected;
			exception_reg[crc_pkg::task_lsb +: crc_pkg::key_width] <= comparator_task_id;
			success_reg[comparator_task_id] <= !comparator_mismatch_detected;
			// two bits per task, task k at 2k+1..2k
			if (comparator_mismatch_detected)
				fail_reg[2*comparator_task_id +: 2] <= comparator_logical_core_id;
		end
	end

	forward_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0({csr_cat_write, csr_maxcount_write, csr_pointer_start_write,
			csr_pointer_end_write}));

	status_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		csr_status_ack |=> !csr_status_ack);

endmodule

// File: source/fingerprint_comparator.sv
`timescale 1ns/1ps

module fingerprint_comparator (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  fprint_write,
	input  logic [crc_pkg::key_width-1:0]         fprint_physical_core,
	input  logic [crc_pkg::data_width-1:0]        fprint_data,
	output logic [crc_pkg::key_width-1:0]         lookup_core,
	input  logic                                  lookup_valid,
	input  logic [crc_pkg::key_width-1:0]         lookup_task,
	input  logic [1:0]                            lookup_logical,
	input  logic [crc_pkg::ram_addr_width-1:0]    maxcount,
	input  logic [crc_pkg::ram_addr_width-1:0]    window_start,
	input  logic [crc_pkg::ram_addr_width-1:0]    window_end,
	input  logic                                  status_ack,
	output logic                                  status_write,
	output logic [crc_pkg::key_width-1:0]         status_task,
	output logic [1:0]                            status_logical,
	output logic                                  status_mismatch
);

	logic [crc_pkg::data_width-1:0] fprint_side0 [crc_pkg::key_size];
	logic [crc_pkg::data_width-1:0] fprint_side1 [crc_pkg::key_size];
	logic [crc_pkg::key_size-1:0] present0;
	logic [crc_pkg::key_size-1:0] present1;
	logic [crc_pkg::ram_addr_width-1:0] count [crc_pkg::key_size];

	logic in_window;
	logic accept;
	logic side;
	logic other_present;
	logic mismatch;
	logic [crc_pkg::ram_addr_width-1:0] next_count;
	logic report;

	assign lookup_core = fprint_physical_core;

	always_comb begin
		in_window = (lookup_task >= window_start) && (lookup_task <= window_end);
		// a pending report blocks new fingerprints
		accept = fprint_write && !status_write && lookup_valid && in_window;
		side = (lookup_logical != 2'd0);
		other_present = side ? present0[lookup_task] : present1[lookup_task];
		mismatch = side ? (fprint_data != fprint_side0[lookup_task]) :
			(fprint_data != fprint_side1[lookup_task]);
		next_count = count[lookup_task] + 1'b1;
		report = accept && other_present && (mismatch || (next_count == maxcount));
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			present0 <= '0;
			present1 <= '0;
			status_write <= 1'b0;
			for (int i = 0; i < crc_pkg::key_size; i++)
				count[i] <= '0;
		end else begin
			if (accept && other_present) begin
				// pair complete
				present0[lookup_task] <= 1'b0;
				present1[lookup_task] <= 1'b0;
				count[lookup_task] <= report ? '0 : next_count;
			end else if (accept && side) begin
				present1[lookup_task] <= 1'b1;
			end else if (accept) begin
				present0[lookup_task] <= 1'b1;
			end
			if (report)
				status_write <= 1'b1;
			else if (status_ack)
				status_write <= 1'b0;
		end
	end

	// only the first side of a pair is kept
	always_ff @(posedge clk) begin
		if (accept && !other_present) begin
			if (side)
				fprint_side1[lookup_task] <= fprint_data;
			else
				fprint_side0[lookup_task] <= fprint_data;
		end
		if (report) begin
			status_task <= lookup_task;
			status_logical <= lookup_logical;
			status_mismatch <= mismatch;
		end
	end

	status_held: assert property (@(posedge clk) disable iff (reset)
		$fell(status_write) |-> $past(status_ack));

endmodule
